/* sim.f */
+incdir+hdl
hdl/lstm_num_pkg.sv
hdl/lstm_ctrl_pkg.sv
hdl/lstm_cfg_regs.sv
hdl/hard_act.sv
hdl/cell_update.sv
hdl/lstm_sequencer.sv
hdl/lstm_cell_top.sv
tb/tb_lstm_cell.sv

/* tb/tb_lstm_cell.sv */
`timescale 1ns/10ps
`include "lstm_macros.svh"

module tb_lstm_cell import lstm_num_pkg::*, lstm_ctrl_pkg::*; ();

  localparam int NUM_PASSES  = 6;
  localparam int TOTAL_ELEMS = 39;   // 4 x 8, then 6, then 1
  localparam int WATCHDOG_NS = (TOTAL_ELEMS + 20 * NUM_PASSES) * 10;

  typedef struct {
    int addr;
    int h;
    int cyc;   // cycle of the accept
  } h_exp_t;

  logic        clk;
  logic        rst;
  logic        cfg_we;
  cfg_reg_t    cfg_addr;
  logic [15:0] cfg_wdata;
  logic [15:0] cfg_rdata;
  logic        x_valid;
  fixed_t      pre_f;
  fixed_t      pre_i;
  fixed_t      pre_g;
  fixed_t      pre_o;
  logic        h_valid;
  fixed_t      h_data;
  cell_addr_t  h_addr;
  logic        busy;
  logic        done;

  logic        exp_acc;    // element driven this cycle will be accepted
  logic        exp_last;   // ... and it is the last of the pass
  int          cyc;
  int unsigned lcg_state;
  int          cell_model [`LSTM_CELL_DEPTH];
  h_exp_t      exp_q [$];

  lstm_cell_top UUT (.*);

  always #5 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////
  // reference arithmetic
  ////////////////////////////////////////////////////////////

  function automatic int clamp_int(input int v, input int lo, input int hi);
    return (v < lo) ? lo : ((v > hi) ? hi : v);
  endfunction

  function automatic int hard_sig(input int x);
    return clamp_int(128 + (x >>> 2), 0, 256);
  endfunction

  function automatic int hard_tanh(input int x);
    return clamp_int(x, -256, 256);
  endfunction

  function automatic int mul_q8(input int a, input int b);
    return (a * b) >>> 8;   // floor toward minus infinity
  endfunction

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_pre(input bit extreme);
    int unsigned r;
    r = lcg_next();
    if (extreme) begin
      case (r[17:16])
        2'd0:    return 32767;
        2'd1:    return -32768;
        2'd2:    return 1024;
        default: return -1024;
      endcase
    end
    return int'((r >> 12) % 1025) - 512;   // spread over +-2.0
  endfunction

  ////////////////////////////////////////////////////////////
  // drive and check helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_idle();
    x_valid  = 1'b0;
    exp_acc  = 1'b0;
    exp_last = 1'b0;
  endtask

  task automatic write_reg(input cfg_reg_t addr, input int data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data[15:0];
    tick();
    cfg_we    = 1'b0;
    cfg_addr  = REG_COUNT;   // a status read would clear the sticky done
  endtask

  task automatic expect_reg(input cfg_reg_t addr, input int value);
    logic [15:0] data;
    cfg_we   = 1'b0;
    cfg_addr = addr;
    @(negedge clk);
    data = cfg_rdata;
    assert (data == value[15:0])
      else stop_run($sformatf("mismatch at %0t ns: %s reads %0d, expected %0d",
                              $time, addr.name(), data, value));
    tick();
    cfg_addr = REG_COUNT;
  endtask

  task automatic drive_elem(input int addr, input bit extreme, input bit last);
    int     pf;
    int     pi;
    int     pg;
    int     po;
    int     cn;
    h_exp_t e;
    pf = rand_pre(extreme);
    pi = rand_pre(extreme);
    pg = rand_pre(extreme);
    po = rand_pre(extreme);
    pre_f = fixed_t'(pf);
    pre_i = fixed_t'(pi);
    pre_g = fixed_t'(pg);
    pre_o = fixed_t'(po);
    cn = mul_q8(hard_sig(pf), cell_model[addr]) + mul_q8(hard_sig(pi), hard_tanh(pg));
    cn = clamp_int(cn, -32768, 32767);
    cell_model[addr] = cn;
    e.addr = addr;
    e.h    = mul_q8(hard_sig(po), hard_tanh(cn));
    e.cyc  = cyc;
    exp_q.push_back(e);
    x_valid  = 1'b1;
    exp_acc  = 1'b1;
    exp_last = last;
  endtask

  task automatic wait_done();
    do @(negedge clk); while (!done);
    tick();
  endtask

  task automatic run_pass(input int n, input bit extreme, input bit gaps, input bit restart);
    int          k;
    bit          gap_prev;
    int unsigned r;
    cfg_we    = 1'b1;
    cfg_addr  = REG_CTRL;
    cfg_wdata = 16'h0001;   // start
    @(negedge clk);
    assert (!busy) else stop_run($sformatf("mismatch at %0t ns: busy before start", $time));
    tick();
    cfg_we   = 1'b0;
    cfg_addr = REG_COUNT;
    @(negedge clk);
    assert (busy) else stop_run($sformatf("mismatch at %0t ns: busy did not rise", $time));
    tick();   // sequencer now in run
    k = 0;
    gap_prev = 1'b0;
    while (k < n) begin
      r = lcg_next();
      if (gaps && !gap_prev && r[20]) begin
        drive_idle();
        gap_prev = 1'b1;
      end else begin
        drive_elem(k, extreme, k == n - 1);
        if (restart && k == 2) begin
          cfg_we    = 1'b1;   // start again while busy
          cfg_addr  = REG_CTRL;
          cfg_wdata = 16'h0001;
        end
        k++;
        gap_prev = 1'b0;
      end
      tick();
      cfg_we   = 1'b0;
      cfg_addr = REG_COUNT;
    end
    repeat (2) begin
      x_valid  = 1'b1;   // past the count and dropped
      exp_acc  = 1'b0;
      exp_last = 1'b0;
      pre_f    = fixed_t'(rand_pre(1'b0));
      tick();
    end
    drive_idle();
    wait_done();
    assert (exp_q.size() == 0)
      else stop_run($sformatf("%0d outputs of the pass never appeared", exp_q.size()));
  endtask

  ////////////////////////////////////////////////////////////
  // output checks
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    h_exp_t e;
    if (rst && h_valid) begin
      assert (exp_q.size() != 0)
        else stop_run($sformatf("h_valid at %0t ns with no element pending", $time));
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (h_addr == e.addr)
          else stop_run($sformatf("mismatch at %0t ns: h_addr %0d, expected %0d",
                                  $time, h_addr, e.addr));
        assert (h_data == e.h)
          else stop_run($sformatf("mismatch at %0t ns: h_data %0d, expected %0d at addr %0d",
                                  $time, h_data, e.h, e.addr));
        assert (cyc == e.cyc + `LSTM_PIPE_LAT)
          else stop_run($sformatf("mismatch at %0t ns: h in cycle %0d, accept in %0d",
                                  $time, cyc, e.cyc));
      end
    end
  end

  a_h_after_acc: assert property (@(posedge clk) disable iff (!rst)
    exp_acc |-> ##(`LSTM_PIPE_LAT) h_valid)
    else stop_run($sformatf("mismatch at %0t ns: h_valid missing after accept", $time));

  a_h_needs_acc: assert property (@(posedge clk) disable iff (!rst)
    h_valid |-> $past(exp_acc, `LSTM_PIPE_LAT))
    else stop_run($sformatf("mismatch at %0t ns: h_valid without accept", $time));

  a_done_time: assert property (@(posedge clk) disable iff (!rst)
    exp_last |-> ##(`LSTM_PIPE_LAT + 1) done)
    else stop_run($sformatf("mismatch at %0t ns: done not 5 cycles after last", $time));

  a_done_once: assert property (@(posedge clk) disable iff (!rst)
    done |-> $past(exp_last, `LSTM_PIPE_LAT + 1))
    else stop_run($sformatf("mismatch at %0t ns: unexpected done", $time));

  a_busy_falls: assert property (@(posedge clk) disable iff (!rst)
    done |-> !busy && $past(busy))
    else stop_run($sformatf("mismatch at %0t ns: busy did not fall with done", $time));

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    #(WATCHDOG_NS);
    stop_run($sformatf("timeout at %0t ns: the run took too long", $time));
  end

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = REG_COUNT;
    cfg_wdata = '0;
    pre_f = '0;
    pre_i = '0;
    pre_g = '0;
    pre_o = '0;
    cyc = 0;
    lcg_state = 61081;
    drive_idle();
    foreach (cell_model[a]) cell_model[a] = 0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b1;
    @(negedge clk);
    assert (!busy && !done && !h_valid)
      else stop_run($sformatf("mismatch at %0t ns: outputs not idle after reset", $time));
    tick();
    expect_reg(REG_COUNT, `LSTM_CELL_DEPTH);
    expect_reg(REG_STATUS, 0);
    repeat (3) begin
      x_valid = 1'b1;   // idle strobes give no output
      tick();
    end
    drive_idle();
    write_reg(REG_COUNT, 8);
    run_pass(8, 1'b0, 1'b0, 1'b0);   // from cleared state
    expect_reg(REG_STATUS, 2);   // sticky done reads once
    expect_reg(REG_STATUS, 0);
    run_pass(8, 1'b0, 1'b0, 1'b1);
    run_pass(8, 1'b1, 1'b0, 1'b0);   // clamp regions
    write_reg(REG_CTRL, 2);   // clear cell state
    foreach (cell_model[a]) cell_model[a] = 0;
    tick();
    run_pass(8, 1'b0, 1'b0, 1'b0);
    write_reg(REG_COUNT, 0);
    expect_reg(REG_COUNT, 8);
    write_reg(REG_COUNT, 65);
    expect_reg(REG_COUNT, 8);
    write_reg(REG_COUNT, 6);
    run_pass(6, 1'b0, 1'b1, 1'b0);   // gaps in x_valid
    write_reg(REG_COUNT, 1);
    run_pass(1, 1'b0, 1'b0, 1'b0);
    repeat (3) tick();   // no stray output after the last pass
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* hdl/lstm_cell_top.sv */
`timescale 1ns/10ps
`include "lstm_macros.svh"

module lstm_cell_top import lstm_num_pkg::*, lstm_ctrl_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cfg_we,
  input  cfg_reg_t                  cfg_addr,
  input  logic [$bits(fixed_t)-1:0] cfg_wdata,
  input  logic                      x_valid,
  input  fixed_t                    pre_f,
  input  fixed_t                    pre_i,
  input  fixed_t                    pre_g,
  input  fixed_t                    pre_o,
  output logic [$bits(fixed_t)-1:0] cfg_rdata,
  output logic                      h_valid,
  output fixed_t                    h_data,
  output cell_addr_t                h_addr,
  output logic                      busy,
  output logic                      done
);

  logic [`LSTM_CELL_AW:0] elem_count;
  logic                   start_pulse;
  logic                   clear_pulse;
  logic                   accept;
  cell_addr_t             acc_addr;

  lstm_cfg_regs u_cfg_regs (
    .clk        (clk),
    .rst        (rst),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .busy       (busy),
    .done       (done),
    .cfg_rdata  (cfg_rdata),
    .elem_count (elem_count),
    .start_pulse(start_pulse),
    .clear_pulse(clear_pulse)
  );

  lstm_sequencer u_sequencer (
    .clk        (clk),
    .rst        (rst),
    .start_pulse(start_pulse),
    .elem_count (elem_count),
    .x_valid    (x_valid),
    .accept     (accept),
    .acc_addr   (acc_addr),
    .busy       (busy),
    .done       (done)
  );

  cell_update u_cell_update (
    .clk        (clk),
    .rst        (rst),
    .accept     (accept),
    .acc_addr   (acc_addr),
    .pre_f      (pre_f),
    .pre_i      (pre_i),
    .pre_g      (pre_g),
    .pre_o      (pre_o),
    .clear_pulse(clear_pulse),
    .h_valid    (h_valid),
    .h_data     (h_data),
    .h_addr     (h_addr)
  );

endmodule

/* hdl/lstm_sequencer.sv */
`timescale 1ns/10ps
`include "lstm_macros.svh"

module lstm_sequencer import lstm_num_pkg::*, lstm_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_pulse,
  input  logic [`LSTM_CELL_AW:0] elem_count,
  input  logic                   x_valid,
  output logic                   accept,
  output cell_addr_t             acc_addr,
  output logic                   busy,
  output logic                   done
);

  localparam int DW = $clog2(`LSTM_PIPE_LAT);

  seq_state_t             state;
  seq_state_t             state_next;
  logic [`LSTM_CELL_AW:0] elem_cnt;    // accepts so far in this pass
  logic [DW-1:0]          drain_cnt;
  logic                   last_accept;

  assign accept      = (state == SEQ_RUN) && x_valid;
  assign last_accept = accept && ((elem_cnt + 1'b1) >= elem_count);
  assign acc_addr    = elem_cnt[`LSTM_CELL_AW-1:0];
  assign busy        = (state == SEQ_RUN) || (state == SEQ_DRAIN) || start_pulse;
  assign done        = (state == SEQ_STOP);

  ////////////////////////////////////////////////////////////
  // phase FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      SEQ_IDLE, SEQ_STOP: state_next = start_pulse ? SEQ_RUN : SEQ_IDLE;
      SEQ_RUN: begin
        if (last_accept) begin
          state_next = SEQ_DRAIN;
        end
      end
      SEQ_DRAIN: begin
        if (drain_cnt == DW'(`LSTM_PIPE_LAT - 1)) begin
          state_next = SEQ_STOP;   // last write-back is done
        end
      end
      default: state_next = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state     <= SEQ_IDLE;
      elem_cnt  <= '0;
      drain_cnt <= '0;
    end else begin
      state <= state_next;
      if (state != SEQ_RUN) begin
        elem_cnt <= '0;   // every pass starts at address 0
      end else if (accept) begin
        elem_cnt <= elem_cnt + 1'b1;
      end
      if (state == SEQ_DRAIN) begin
        drain_cnt <= drain_cnt + 1'b1;
      end else begin
        drain_cnt <= '0;
      end
    end
  end

  a_accept_in_run: assert property (@(posedge clk) disable iff (!rst)
    accept |-> (state == SEQ_RUN) && (elem_cnt < elem_count))
    else $error("accept outside run or past count");

endmodule

/* hdl/cell_update.sv */
`timescale 1ns/10ps
`include "lstm_macros.svh"

module cell_update import lstm_num_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       accept,
  input  cell_addr_t acc_addr,
  input  fixed_t     pre_f,
  input  fixed_t     pre_i,
  input  fixed_t     pre_g,
  input  fixed_t     pre_o,
  input  logic       clear_pulse,
  output logic       h_valid,
  output fixed_t     h_data,
  output cell_addr_t h_addr
);

  localparam int PW = 2 * `LSTM_DATA_W;   // full product width

  // saturation bounds for c_new
  localparam logic signed [PW:0] C_MAX = (2 ** (`LSTM_DATA_W - 1)) - 1;
  localparam logic signed [PW:0] C_MIN = -(2 ** (`LSTM_DATA_W - 1));

  fixed_t                      c_mem [`LSTM_CELL_DEPTH];
  logic [`LSTM_CELL_DEPTH-1:0] c_written;   // entry holds data

  // stage 1
  fixed_t     f_act;
  fixed_t     i_act;
  fixed_t     g_act;
  fixed_t     o_act;
  fixed_t     c_old;
  cell_addr_t a1;
  logic       v1;

  // stage 2
  logic signed [PW-1:0] fc_prod;
  logic signed [PW-1:0] ig_prod;
  logic signed [PW:0]   c_sum;
  fixed_t               c_sat;
  fixed_t               c2;
  fixed_t               o2;
  cell_addr_t           a2;
  logic                 v2;

  // stage 3
  fixed_t     c_tanh;
  fixed_t     o3;
  cell_addr_t a3;
  logic       v3;

  // stage 4
  logic signed [PW-1:0] h_prod;

  ////////////////////////////////////////////////////////////
  // stage 1 gate activations and cell read
  ////////////////////////////////////////////////////////////

  hard_act #(.kind(ACT_SIGMOID)) u_act_f (.clk(clk), .rst(rst), .x(pre_f), .y(f_act));
  hard_act #(.kind(ACT_SIGMOID)) u_act_i (.clk(clk), .rst(rst), .x(pre_i), .y(i_act));
  hard_act #(.kind(ACT_TANH))    u_act_g (.clk(clk), .rst(rst), .x(pre_g), .y(g_act));
  hard_act #(.kind(ACT_SIGMOID)) u_act_o (.clk(clk), .rst(rst), .x(pre_o), .y(o_act));

  always_ff @(posedge clk) begin
    a1    <= acc_addr;
    c_old <= c_written[acc_addr] ? c_mem[acc_addr] : '0;   // unwritten reads 0
  end

  ////////////////////////////////////////////////////////////
  // stage 2 forms c_new = f*c + i*g and writes it back
  ////////////////////////////////////////////////////////////

  always_comb begin
    fc_prod = (f_act * c_old) >>> `LSTM_FRAC_W;
    ig_prod = (i_act * g_act) >>> `LSTM_FRAC_W;
    c_sum   = fc_prod + ig_prod;
    if (c_sum > C_MAX) begin
      c_sat = C_MAX[`LSTM_DATA_W-1:0];
    end else if (c_sum < C_MIN) begin
      c_sat = C_MIN[`LSTM_DATA_W-1:0];
    end else begin
      c_sat = c_sum[`LSTM_DATA_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (v1) begin
      c_mem[a1] <= c_sat;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      c_written <= '0;
    end else if (clear_pulse) begin
      c_written <= '0;   // clear wins over a same-cycle write
    end else if (v1) begin
      c_written[a1] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    c2 <= c_sat;
    o2 <= o_act;
    a2 <= a1;
  end

  ////////////////////////////////////////////////////////////
  // stages 3 and 4 form tanh(c_new) and h = o * tanh(c_new)
  ////////////////////////////////////////////////////////////

  hard_act #(.kind(ACT_TANH)) u_act_c (.clk(clk), .rst(rst), .x(c2), .y(c_tanh));

  always_ff @(posedge clk) begin
    o3 <= o2;
    a3 <= a2;
  end

  assign h_prod = (o3 * c_tanh) >>> `LSTM_FRAC_W;

  always_ff @(posedge clk) begin
    h_data <= h_prod[`LSTM_DATA_W-1:0];   // |h| <= 1.0
    h_addr <= a3;
  end

  // valid shift chain
  always_ff @(posedge clk) begin
    if (!rst) begin
      v1      <= 1'b0;
      v2      <= 1'b0;
      v3      <= 1'b0;
      h_valid <= 1'b0;
    end else begin
      v1      <= accept;
      v2      <= v1;
      v3      <= v2;
      h_valid <= v3;
    end
  end

  // address chain must stay aligned with the valid chain
  a_accept_to_h: assert property (@(posedge clk) disable iff (!rst)
    accept |-> ##(`LSTM_PIPE_LAT) (h_valid && (h_addr == $past(acc_addr, `LSTM_PIPE_LAT))))
    else $error("h_valid or h_addr wrong after accept");

endmodule

/* hdl/hard_act.sv */
`timescale 1ns/10ps
`include "lstm_macros.svh"

module hard_act import lstm_num_pkg::*; #(
  parameter act_kind_t kind = ACT_SIGMOID
) (
  input  logic   clk,
  input  logic   rst,
  input  fixed_t x,
  output fixed_t y
);

  localparam int EW = `LSTM_DATA_W + 2;   // two guard bits

  // clamp limits in the extended width
  localparam logic signed [EW-1:0] HI = FIX_ONE;
  localparam logic signed [EW-1:0] LO = (kind == ACT_SIGMOID) ? 0 : -FIX_ONE;

  logic signed [EW-1:0] lin;   // before clamping
  logic signed [EW-1:0] sat;

  ////////////////////////////////////////////////////////////
  // piecewise linear part
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (kind == ACT_SIGMOID) begin
      lin = (HI >>> 1) + (x >>> 2);   // 0.5 + x/4
    end else begin
      lin = x;
    end
  end

  ////////////////////////////////////////////////////////////
  // clamp in both directions
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (lin > HI) begin
      sat = HI;
    end else if (lin < LO) begin
      sat = LO;
    end else begin
      sat = lin;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      y <= '0;
    end else begin
      y <= sat[`LSTM_DATA_W-1:0];   // fits after clamp
    end
  end

endmodule

/* hdl/lstm_cfg_regs.sv */
`timescale 1ns/10ps
`include "lstm_macros.svh"

module lstm_cfg_regs import lstm_num_pkg::*, lstm_ctrl_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cfg_we,
  input  cfg_reg_t                  cfg_addr,
  input  logic [$bits(fixed_t)-1:0] cfg_wdata,
  input  logic                      busy,
  input  logic                      done,
  output logic [$bits(fixed_t)-1:0] cfg_rdata,
  output logic [`LSTM_CELL_AW:0]    elem_count,
  output logic                      start_pulse,
  output logic                      clear_pulse
);

  logic done_seen;   // sticky done
  logic ctrl_wr;
  logic count_wr;
  logic count_ok;
  logic status_rd;

  assign ctrl_wr   = cfg_we && (cfg_addr == REG_CTRL);
  assign count_wr  = cfg_we && (cfg_addr == REG_COUNT);
  assign status_rd = !cfg_we && (cfg_addr == REG_STATUS);
  assign count_ok  = (cfg_wdata != '0) && (cfg_wdata <= `LSTM_CELL_DEPTH);   // 1..64 only

  always_ff @(posedge clk) begin
    if (!rst) begin
      elem_count  <= `LSTM_CELL_DEPTH;
      start_pulse <= 1'b0;
      clear_pulse <= 1'b0;
      done_seen   <= 1'b0;
    end else begin
      start_pulse <= ctrl_wr && cfg_wdata[CTRL_START_BIT];
      clear_pulse <= ctrl_wr && cfg_wdata[CTRL_CLEAR_BIT];
      if (count_wr && count_ok) begin
        elem_count <= cfg_wdata[`LSTM_CELL_AW:0];
      end
      if (done) begin
        done_seen <= 1'b1;   // a new pass end beats a read
      end else if (status_rd) begin
        done_seen <= 1'b0;
      end
    end
  end

  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      REG_COUNT: cfg_rdata[`LSTM_CELL_AW:0] = elem_count;
      REG_STATUS: begin
        cfg_rdata[STAT_BUSY_BIT] = busy;
        cfg_rdata[STAT_DONE_BIT] = done_seen;
      end
      default: cfg_rdata = '0;   // ctrl reads back zero
    endcase
  end

  a_count_range: assert property (@(posedge clk) disable iff (!rst)
    elem_count inside {[1:`LSTM_CELL_DEPTH]})
    else $error("elem_count out of range");

endmodule

/* hdl/lstm_ctrl_pkg.sv */
`include "lstm_macros.svh"

package lstm_ctrl_pkg;

  // sequencer phases
  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_RUN   = 2'd1,   // accepting elements
    SEQ_DRAIN = 2'd2,   // pipeline empties
    SEQ_STOP  = 2'd3    // one cycle, done pulse
  } seq_state_t;

  // configuration register map
  typedef enum logic [`LSTM_CFG_AW-1:0] {
    REG_COUNT  = 2'd0,   // r/w element count
    REG_CTRL   = 2'd1,   // w only
    REG_STATUS = 2'd2    // r only
  } cfg_reg_t;

  // REG_CTRL bits
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_CLEAR_BIT = 1;

  // REG_STATUS bits
  localparam int STAT_BUSY_BIT = 0;
  localparam int STAT_DONE_BIT = 1;   // sticky until read

endpackage

/* hdl/lstm_num_pkg.sv */
`include "lstm_macros.svh"

package lstm_num_pkg;

  ////////////////////////////////////////////////////////////
  // fixed point
  ////////////////////////////////////////////////////////////

  typedef logic signed [`LSTM_DATA_W-1:0] fixed_t;   // Q8.8

  // 1.0 in Q8.8
  localparam fixed_t FIX_ONE = fixed_t'(1 << `LSTM_FRAC_W);

  ////////////////////////////////////////////////////////////
  // cell state addressing
  ////////////////////////////////////////////////////////////

  typedef logic [`LSTM_CELL_AW-1:0] cell_addr_t;

  ////////////////////////////////////////////////////////////
  // activation selection
  ////////////////////////////////////////////////////////////

  typedef enum logic [0:0] {
    ACT_SIGMOID = 1'b0,   // 0.5 + x/4, clamped to [0, 1]
    ACT_TANH    = 1'b1    // x, clamped to [-1, 1]
  } act_kind_t;

endpackage

/* hdl/lstm_macros.svh */
`ifndef LSTM_MACROS_SVH
`define LSTM_MACROS_SVH

////////////////////////////////////////////////////////////
// data format
////////////////////////////////////////////////////////////

`define LSTM_DATA_W      16   // signed Q8.8 word
`define LSTM_FRAC_W      8    // one = 256

////////////////////////////////////////////////////////////
// cell state memory
////////////////////////////////////////////////////////////

`define LSTM_CELL_DEPTH  64   // cell entries
`define LSTM_CELL_AW     6    // log2 of depth

////////////////////////////////////////////////////////////
// control
////////////////////////////////////////////////////////////

`define LSTM_PIPE_LAT    4    // accept to h_valid
`define LSTM_CFG_AW      2    // config address width

`endif
